//--- include/buf_router_defines.svh
`ifndef BUF_ROUTER_DEFINES_SVH
`define BUF_ROUTER_DEFINES_SVH

// word width on both the SDRAM side and the bank side
`define DATA_WIDTH 16

// input feature map group
`define IFM_BANKS 2
`define IFM_SIZE 8
`define IFM_ADR_W 3

// weight group, one kernel per bank
`define WGT_BANKS 4
`define KERNEL_SIZE 9
`define WGT_ADR_W 4

`endif

//--- hw/buf_router_pkg.sv
`include "buf_router_defines.svh"

package buf_router_pkg;

	// values 4 to 7 are unused and behave as idle
	typedef enum logic [2:0]
	{
		phase_idle      = 3'd0,
		phase_fill_ifm  = 3'd1,
		phase_fill_wgt  = 3'd2,
		phase_conv_read = 3'd3
	} read_phase_e;

	typedef logic [`DATA_WIDTH - 1 : 0] word_t;
	typedef logic [`IFM_ADR_W - 1 : 0] ifm_addr_t;
	typedef logic [`WGT_ADR_W - 1 : 0] wgt_addr_t;

	// one bank port, strobes active low
	typedef struct packed
	{
		logic      read_n;
		logic      write_n;
		ifm_addr_t addr;
		word_t     wdata;
	} ifm_req_t;

	typedef struct packed
	{
		logic      read_n;
		logic      write_n;
		wgt_addr_t addr;
		word_t     wdata;
	} wgt_req_t;

	// read request from the conv engine
	typedef struct packed
	{
		logic      read_n;
		ifm_addr_t addr;
	} ifm_conv_rd_t;

	typedef struct packed
	{
		logic      read_n;
		wgt_addr_t addr;
	} wgt_conv_rd_t;

endpackage

//--- hw/bank_fill_seq.sv
`timescale 1ns/100ps

module bank_fill_seq
	import buf_router_pkg::*;
#(
	parameter type req_t = ifm_req_t,
	parameter int num_banks = 2,
	parameter int depth = 8,
	parameter read_phase_e fill_phase = phase_fill_ifm
)
(
	input  logic        clk,
	input  logic        arst_n,
	input  read_phase_e phase,
	input  logic        sdram_rdval,
	input  word_t       sdram_readdata,
	output req_t        fill_req [num_banks],
	output logic        done
);

	// address width follows from the request layout
	localparam int addr_w = $bits(req_t) - $bits(word_t) - 2;
	localparam int ptr_w = (num_banks > 1) ? $clog2(num_banks) : 1;
	localparam logic [ptr_w - 1 : 0] last_bank = ptr_w'(num_banks - 1);
	localparam logic [addr_w - 1 : 0] last_word = addr_w'(depth - 1);

	logic                  in_phase;
	logic                  accept;
	logic                  word_last;
	logic                  bank_last;
	logic [ptr_w - 1 : 0]  bank_ptr;
	logic [addr_w - 1 : 0] word_idx;
	logic                  full;
	logic [num_banks - 1 : 0] wr_n;
	logic [addr_w - 1 : 0] wr_addr;
	word_t                 wr_data;

	assign in_phase = (phase == fill_phase);
	// words arriving once the group is full are dropped
	assign accept = in_phase && sdram_rdval && !full;
	assign word_last = (word_idx == last_word);
	assign bank_last = (bank_ptr == last_bank);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bank_ptr <= '0;
			word_idx <= '0;
			full <= 1'b0;
			done <= 1'b0;
			wr_n <= '1;
		end
		else
		begin
			// write strobe is a single cycle pulse
			wr_n <= '1;
			done <= in_phase && full;
			if (!in_phase)
			begin
				bank_ptr <= '0;
				word_idx <= '0;
				full <= 1'b0;
			end
			else if (accept)
			begin
				wr_n[bank_ptr] <= 1'b0;
				if (word_last)
				begin
					word_idx <= '0;
					if (bank_last)
						full <= 1'b1;
					else
						bank_ptr <= bank_ptr + 1'b1;
				end
				else
				begin
					word_idx <= word_idx + 1'b1;
				end
			end
		end
	end

	// one shared address and word, only the strobed bank takes it
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			wr_addr <= word_idx;
			wr_data <= sdram_readdata;
		end
	end

	always_comb
	begin
		for (int i = 0; i < num_banks; i++)
		begin
			fill_req[i].read_n = 1'b1;
			fill_req[i].write_n = wr_n[i];
			fill_req[i].addr = wr_addr;
			fill_req[i].wdata = wr_data;
		end
	end

endmodule

//--- hw/bank_port_mux.sv
`timescale 1ns/100ps

module bank_port_mux
	import buf_router_pkg::*;
#(
	parameter type req_t = ifm_req_t,
	parameter type rd_t = ifm_conv_rd_t,
	parameter int num_banks = 2
)
(
	input  logic        clk,
	input  logic        arst_n,
	input  read_phase_e phase,
	input  req_t        fill_req [num_banks],
	input  rd_t         conv_rd [num_banks],
	output req_t        bank_req [num_banks],
	input  word_t       bank_rdata [num_banks],
	output word_t       conv_rdata [num_banks]
);

	logic conv_sel;

	// conv engine owns the read side only in this phase
	assign conv_sel = (phase == phase_conv_read);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < num_banks; i++)
			begin
				bank_req[i].read_n <= 1'b1;
				bank_req[i].write_n <= 1'b1;
				bank_req[i].addr <= '0;
				bank_req[i].wdata <= '0;
			end
		end
		else if (conv_sel)
		begin
			for (int i = 0; i < num_banks; i++)
			begin
				bank_req[i].read_n <= conv_rd[i].read_n;
				// no writes while the conv engine reads
				bank_req[i].write_n <= 1'b1;
				bank_req[i].addr <= conv_rd[i].addr;
			end
		end
		else
		begin
			// fill side keeps read_n high, idle keeps both high
			for (int i = 0; i < num_banks; i++)
			begin
				bank_req[i] <= fill_req[i];
			end
		end
	end

	// return path, one stage behind the bank output
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < num_banks; i++)
			begin
				conv_rdata[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < num_banks; i++)
			begin
				conv_rdata[i] <= bank_rdata[i];
			end
		end
	end

endmodule

//--- hw/buf_router_top.sv
`timescale 1ns/100ps
`include "buf_router_defines.svh"

module buf_router_top
	import buf_router_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	input  read_phase_e  phase,
	input  logic         sdram_rdval,
	input  word_t        sdram_readdata,
	output ifm_req_t     ifm_bank [`IFM_BANKS],
	input  word_t        ifm_rdata [`IFM_BANKS],
	output wgt_req_t     wgt_bank [`WGT_BANKS],
	input  word_t        wgt_rdata [`WGT_BANKS],
	input  ifm_conv_rd_t conv_ifm_rd [`IFM_BANKS],
	output word_t        conv_ifm_rdata [`IFM_BANKS],
	input  wgt_conv_rd_t conv_wgt_rd [`WGT_BANKS],
	output word_t        conv_wgt_rdata [`WGT_BANKS],
	output logic         ifm_done,
	output logic         wgt_done
);

	ifm_req_t ifm_fill_req [`IFM_BANKS];
	wgt_req_t wgt_fill_req [`WGT_BANKS];

	// input feature map group
	bank_fill_seq #(
		.req_t      (ifm_req_t),
		.num_banks  (`IFM_BANKS),
		.depth      (`IFM_SIZE),
		.fill_phase (phase_fill_ifm)
	) ifm_fill (
		.clk            (clk),
		.arst_n         (arst_n),
		.phase          (phase),
		.sdram_rdval    (sdram_rdval),
		.sdram_readdata (sdram_readdata),
		.fill_req       (ifm_fill_req),
		.done           (ifm_done)
	);

	bank_port_mux #(
		.req_t     (ifm_req_t),
		.rd_t      (ifm_conv_rd_t),
		.num_banks (`IFM_BANKS)
	) ifm_mux (
		.clk        (clk),
		.arst_n     (arst_n),
		.phase      (phase),
		.fill_req   (ifm_fill_req),
		.conv_rd    (conv_ifm_rd),
		.bank_req   (ifm_bank),
		.bank_rdata (ifm_rdata),
		.conv_rdata (conv_ifm_rdata)
	);

	// weight group
	bank_fill_seq #(
		.req_t      (wgt_req_t),
		.num_banks  (`WGT_BANKS),
		.depth      (`KERNEL_SIZE),
		.fill_phase (phase_fill_wgt)
	) wgt_fill (
		.clk            (clk),
		.arst_n         (arst_n),
		.phase          (phase),
		.sdram_rdval    (sdram_rdval),
		.sdram_readdata (sdram_readdata),
		.fill_req       (wgt_fill_req),
		.done           (wgt_done)
	);

	bank_port_mux #(
		.req_t     (wgt_req_t),
		.rd_t      (wgt_conv_rd_t),
		.num_banks (`WGT_BANKS)
	) wgt_mux (
		.clk        (clk),
		.arst_n     (arst_n),
		.phase      (phase),
		.fill_req   (wgt_fill_req),
		.conv_rd    (conv_wgt_rd),
		.bank_req   (wgt_bank),
		.bank_rdata (wgt_rdata),
		.conv_rdata (conv_wgt_rdata)
	);

endmodule

//--- verification/buf_router_properties.sv
`timescale 1ns/100ps
`include "buf_router_defines.svh"

module buf_router_properties
	import buf_router_pkg::*;
(
	input logic        clk,
	input logic        arst_n,
	input read_phase_e phase,
	input ifm_req_t    ifm_bank [`IFM_BANKS],
	input wgt_req_t    wgt_bank [`WGT_BANKS],
	input logic        ifm_done,
	input logic        wgt_done
);

	int fail_count = 0;
	logic [`IFM_BANKS - 1 : 0] ifm_wr;
	logic [`IFM_BANKS - 1 : 0] ifm_clash;
	logic [`WGT_BANKS - 1 : 0] wgt_wr;
	logic [`WGT_BANKS - 1 : 0] wgt_clash;

	// strobes are active low
	always_comb
	begin
		for (int i = 0; i < `IFM_BANKS; i++)
		begin
			ifm_wr[i] = !ifm_bank[i].write_n;
			ifm_clash[i] = !ifm_bank[i].write_n && !ifm_bank[i].read_n;
		end
		for (int i = 0; i < `WGT_BANKS; i++)
		begin
			wgt_wr[i] = !wgt_bank[i].write_n;
			wgt_clash[i] = !wgt_bank[i].write_n && !wgt_bank[i].read_n;
		end
	end

	strobe_clash: assert property (@(posedge clk) disable iff (!arst_n)
		ifm_clash == '0 && wgt_clash == '0)
	else
	begin
		fail_count++;
		$error("bank has read_n and write_n low together");
	end

	one_write: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(ifm_wr) && $onehot0(wgt_wr))
	else
	begin
		fail_count++;
		$error("more than one write pulse in a group");
	end

	done_held: assert property (@(posedge clk) disable iff (!arst_n)
		(ifm_done && $stable(phase) |=> ifm_done) and
		(wgt_done && $stable(phase) |=> wgt_done))
	else
	begin
		fail_count++;
		$error("done dropped while the phase stayed the same");
	end

	// bank port lags the phase by one edge
	no_conv_write: assert property (@(posedge clk) disable iff (!arst_n)
		phase == phase_conv_read |=> ifm_wr == '0 && wgt_wr == '0)
	else
	begin
		fail_count++;
		$error("write pulse during conv read");
	end

endmodule

bind buf_router_top buf_router_properties props0 (.*);

//--- verification/buf_router_tb.sv
`timescale 1ns/100ps
`include "buf_router_defines.svh"

module buf_router_tb
	import buf_router_pkg::*;
();

	localparam int reset_cycles = 16;
	localparam int max_gap = 3;
	localparam int stim_depth = 64;
	// index 0 is the input group, 1 the weight group
	localparam read_phase_e fill_of [2] = '{phase_fill_ifm, phase_fill_wgt};
	localparam int banks_of [2] = '{`IFM_BANKS, `WGT_BANKS};
	localparam int depth_of [2] = '{`IFM_SIZE, `KERNEL_SIZE};

	logic         clk;
	logic         arst_n;
	read_phase_e  phase;
	logic         sdram_rdval;
	word_t        sdram_readdata;
	ifm_req_t     ifm_bank [`IFM_BANKS];
	word_t        ifm_rdata [`IFM_BANKS];
	wgt_req_t     wgt_bank [`WGT_BANKS];
	word_t        wgt_rdata [`WGT_BANKS];
	ifm_conv_rd_t conv_ifm_rd [`IFM_BANKS];
	word_t        conv_ifm_rdata [`IFM_BANKS];
	wgt_conv_rd_t conv_wgt_rd [`WGT_BANKS];
	word_t        conv_wgt_rdata [`WGT_BANKS];
	logic         ifm_done;
	logic         wgt_done;

	word_t       bank_mem [2][`WGT_BANKS][16];
	word_t       ref_mem [2][`WGT_BANKS][16];
	logic [31:0] stim [stim_depth];
	// pending writes as bank, address, word
	logic [31:0] wr_q [2][$];
	logic [31:0] rd_q [$];
	int          rd_due [$];
	int          ref_bank [2];
	int          ref_word [2];
	int          writes [2];
	string       grp_name [2] = '{"ifm_bank", "wgt_bank"};
	int          cycle = 0;
	int          limit = 0;
	int          errors = 0;

	buf_router_top dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (limit > 0 && cycle > limit)
		begin
			$display("timeout after %0d cycles, the stimulus never finished", cycle);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic word_t fill_pattern(int g, int b, int a);
		return word_t'(16'h5000 + g * 16'h0400 + b * 16'h0040 + a);
	endfunction

	// bank models, one cycle registered read
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int g = 0; g < 2; g++)
				for (int b = 0; b < `WGT_BANKS; b++)
					for (int a = 0; a < 16; a++)
						bank_mem[g][b][a] <= fill_pattern(g, b, a);
			ifm_rdata <= '{default: '0};
			wgt_rdata <= '{default: '0};
		end
		else
		begin
			for (int b = 0; b < `IFM_BANKS; b++)
			begin
				if (!ifm_bank[b].write_n)
					bank_mem[0][b][ifm_bank[b].addr] <= ifm_bank[b].wdata;
				if (!ifm_bank[b].read_n)
					ifm_rdata[b] <= bank_mem[0][b][ifm_bank[b].addr];
			end
			for (int b = 0; b < `WGT_BANKS; b++)
			begin
				if (!wgt_bank[b].write_n)
					bank_mem[1][b][wgt_bank[b].addr] <= wgt_bank[b].wdata;
				if (!wgt_bank[b].read_n)
					wgt_rdata[b] <= bank_mem[1][b][wgt_bank[b].addr];
			end
		end
	end

	task automatic check(string name, logic [31:0] got, logic [31:0] expected);
		if (got !== expected)
		begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic take_write(int g, int b, logic [7:0] addr, word_t data);
		logic [31:0] e;
		writes[g]++;
		if (wr_q[g].size() == 0)
		begin
			errors++;
			$display("write pulse on %s %0d while no word was pending", grp_name[g], b);
		end
		else
		begin
			e = wr_q[g].pop_front();
			check({grp_name[g], " index"}, b, e[27:24]);
			check({grp_name[g], ".addr"}, addr, e[23:16]);
			check({grp_name[g], ".wdata"}, data, e[15:0]);
		end
	endtask

	// every falling edge, look at write pulses and due read data
	task automatic next_cycle();
		logic [31:0] e;
		@(negedge clk);
		for (int b = 0; b < `IFM_BANKS; b++)
			if (!ifm_bank[b].write_n)
				take_write(0, b, 8'(ifm_bank[b].addr), ifm_bank[b].wdata);
		for (int b = 0; b < `WGT_BANKS; b++)
			if (!wgt_bank[b].write_n)
				take_write(1, b, 8'(wgt_bank[b].addr), wgt_bank[b].wdata);
		while (rd_due.size() > 0 && rd_due[0] <= cycle)
		begin
			e = rd_q.pop_front();
			void'(rd_due.pop_front());
			if (e[28])
				check("conv_wgt_rdata", conv_wgt_rdata[e[27:24]], e[15:0]);
			else
				check("conv_ifm_rdata", conv_ifm_rdata[e[27:24]], e[15:0]);
		end
	endtask

	// reference fill, banks in order, each to its depth
	task automatic accept_word(int g, word_t data);
		if (phase == fill_of[g] && ref_bank[g] < banks_of[g])
		begin
			wr_q[g].push_back({4'h0, 4'(ref_bank[g]), 8'(ref_word[g]), data});
			ref_mem[g][ref_bank[g]][ref_word[g]] = data;
			ref_word[g]++;
			if (ref_word[g] == depth_of[g])
			begin
				ref_word[g] = 0;
				ref_bank[g]++;
			end
		end
	endtask

	task automatic send_words(int count, word_t base);
		for (int i = 0; i < count; i++)
		begin
			sdram_rdval = 1'b1;
			sdram_readdata = base + word_t'(i);
			accept_word(0, sdram_readdata);
			accept_word(1, sdram_readdata);
			next_cycle();
			sdram_rdval = 1'b0;
			repeat ($urandom % (max_gap + 1))
				next_cycle();
		end
	endtask

	task automatic set_phase(read_phase_e p);
		phase = p;
		for (int g = 0; g < 2; g++)
		begin
			if (p != fill_of[g])
			begin
				ref_bank[g] = 0;
				ref_word[g] = 0;
			end
		end
		next_cycle();
	endtask

	// data is due three edges after the request is sampled
	task automatic conv_read(int g, int b, int a);
		if (g == 0)
			conv_ifm_rd[b] = '{read_n: 1'b0, addr: ifm_addr_t'(a)};
		else
			conv_wgt_rd[b] = '{read_n: 1'b0, addr: wgt_addr_t'(a)};
		rd_q.push_back({3'h0, 1'(g), 4'(b), 8'h00, ref_mem[g][b][a]});
		rd_due.push_back(cycle + 3);
		next_cycle();
		conv_ifm_rd = '{default: '1};
		conv_wgt_rd = '{default: '1};
	endtask

	initial
	begin
		logic [31:0] cmd;
		void'($urandom(6965));
		arst_n = 1'b0;
		phase = phase_idle;
		sdram_rdval = 1'b0;
		sdram_readdata = '0;
		conv_ifm_rd = '{default: '1};
		conv_wgt_rd = '{default: '1};
		for (int g = 0; g < 2; g++)
			for (int b = 0; b < `WGT_BANKS; b++)
				for (int a = 0; a < 16; a++)
					ref_mem[g][b][a] = fill_pattern(g, b, a);
		for (int i = 0; i < stim_depth; i++)
			stim[i] = '0;
		$readmemh("verification/buf_router_stimulus.txt", stim);
		// each line is bounded by its count plus one, times the worst gap
		limit = reset_cycles + 8;
		for (int i = 0; i < stim_depth; i++)
			limit += (int'(stim[i][23:16]) + 1) * (max_gap + 4);
		repeat (reset_cycles) @(negedge clk);
		arst_n = 1'b1;
		next_cycle();
		for (int b = 0; b < `WGT_BANKS; b++)
		begin
			if (b < `IFM_BANKS)
			begin
				check("ifm_bank strobes", {ifm_bank[b].read_n, ifm_bank[b].write_n}, 2'b11);
				check("conv_ifm_rdata", conv_ifm_rdata[b], 0);
			end
			check("wgt_bank strobes", {wgt_bank[b].read_n, wgt_bank[b].write_n}, 2'b11);
			check("conv_wgt_rdata", conv_wgt_rdata[b], 0);
		end
		check("ifm_done", ifm_done, 0);
		check("wgt_done", wgt_done, 0);
		for (int i = 0; i < stim_depth && stim[i][31:28] != 4'h0; i++)
		begin
			cmd = stim[i];
			case (cmd[31:28])
				4'h1: set_phase(read_phase_e'(cmd[2:0]));
				4'h2: send_words(cmd[23:16], cmd[15:0]);
				4'h3: repeat (cmd[23:16]) next_cycle();
				4'h4: conv_read(0, cmd[27:24], cmd[23:16]);
				4'h5: conv_read(1, cmd[27:24], cmd[23:16]);
				4'h6:
				begin
					check("ifm_done", ifm_done, cmd[0]);
					check("wgt_done", wgt_done, cmd[1]);
				end
				4'h7:
				begin
					check("ifm_bank write count", writes[0], cmd[7:0]);
					check("wgt_bank write count", writes[1], cmd[15:8]);
					writes[0] = 0;
					writes[1] = 0;
				end
				default:
				begin
					errors++;
					$display("stimulus line %0d holds an unknown command %h", i, cmd);
				end
			endcase
		end
		if (wr_q[0].size() + wr_q[1].size() + rd_q.size() != 0)
		begin
			errors++;
			$display("some expected bank writes or conv read data never arrived");
		end
		for (int g = 0; g < 2; g++)
			for (int b = 0; b < `WGT_BANKS; b++)
				for (int a = 0; a < 16; a++)
					check("bank_mem", bank_mem[g][b][a], ref_mem[g][b][a]);
		$display("summary: %0d check errors, %0d assertion failures", errors,
			dut0.props0.fail_count);
		if (errors + dut0.props0.fail_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- verification/buf_router_stimulus.txt
// each word is C S AA VVVV: command, bank, count or address, value
// 1 phase, 2 sdram words from base, 3 idle, 4 ifm read, 5 wgt read, 6 done, 7 write counts
10000000
20040100 // words in idle are dropped
60000000
10000001
2010a000 // fills both input banks
30030000
60000001
70000010
2003b000 // group full, no writes
30030000
70000000
60000001
10000002
2024c000
30030000
60000002 // ifm_done cleared
70002400
10000007 // unused phase acts as idle
2004e000
30030000
70000000
60000000
10000001
2002f000 // restart at bank 0, address 0
30030000
70000002
10000003
2003d000 // no writes while conv reads
40000000
40010000
40020000
41070000
50000000
51080000
52040000
53080000
30040000
70000000
00000000

//--- list.f
+incdir+include
hw/buf_router_pkg.sv
hw/bank_fill_seq.sv
hw/bank_port_mux.sv
hw/buf_router_top.sv
verification/buf_router_properties.sv
verification/buf_router_tb.sv
